//--- rtl/autoconfPkg.sv
package autoconfPkg;

  //////////////////////////////////////////////////////////////////////
  // Bus data types
  //////////////////////////////////////////////////////////////////////

  typedef logic [3:0] nibbleT;     // One nibble on D31-28
  typedef logic [1:0] boardIdxT;   // Position in the chain

  localparam boardIdxT BOARD_BRIDGE = 2'd0;
  localparam boardIdxT BOARD_LIDE   = 2'd1;
  localparam boardIdxT BOARD_PRO    = 2'd2;  // Expansion ROM board, last in chain

  //////////////////////////////////////////////////////////////////////
  // Descriptor identity
  //////////////////////////////////////////////////////////////////////

  localparam logic [7:0]  BRIDGE_PID = 8'd4;
  localparam logic [7:0]  LIDE_PID   = 8'd3;
  localparam logic [7:0]  PRO_PID    = 8'd200;

  localparam logic [15:0] MFR_ID     = 16'd600;   // Bridge and IDE
  localparam logic [15:0] PRO_MFR_ID = 16'd3643;

  localparam logic [31:0] SERIAL_NUM = 32'd1;

  //////////////////////////////////////////////////////////////////////
  // Register offsets in the configuration space
  //////////////////////////////////////////////////////////////////////

  localparam logic [7:0] OFS_TYPE    = 8'h00;  // Board type, not inverted
  localparam logic [7:0] OFS_SIZE    = 8'h02;  // Size nibble, not inverted
  localparam logic [7:0] OFS_PROD_HI = 8'h04;
  localparam logic [7:0] OFS_PROD_LO = 8'h06;
  localparam logic [7:0] OFS_FLAGS   = 8'h08;
  localparam logic [7:0] OFS_MFR_0   = 8'h10;  // Manufacturer, MS nibble
  localparam logic [7:0] OFS_MFR_3   = 8'h16;  // Manufacturer, LS nibble
  localparam logic [7:0] OFS_SER_0   = 8'h18;  // Serial number, MS nibble
  localparam logic [7:0] OFS_SER_7   = 8'h26;  // Serial number, LS nibble

  localparam logic [7:0] OFS_BASE_HI = 8'h48;
  localparam logic [7:0] OFS_BASE_LO = 8'h4A;

endpackage

//--- rtl/acRegIf.sv
`timescale 1ns/1ps

interface acRegIf
  import autoconfPkg::*;
();

  logic [7:0] regOfs;     // Byte offset, bit 0 always zero
  logic       readStb;
  logic       writeStb;
  nibbleT     wrNibble;
  boardIdxT   boardIdx;
  logic       chainDone;  // All three boards configured

  modport fsm (
    output regOfs, readStb, writeStb, wrNibble,
    input  chainDone
  );

  modport chain (
    output boardIdx, chainDone
  );

  modport data (
    input regOfs, readStb, writeStb, wrNibble, boardIdx, chainDone
  );

endinterface

//--- rtl/acCycleFsm.sv
`timescale 1ns/1ps

module acCycleFsm
  import autoconfPkg::*;
(
  input  logic       CLK40,
  input  logic       RESETn,
  input  logic       autoconfigSpace,
  input  logic       tsN,
  input  logic       rnW,
  input  logic       cpuConfN,
  input  logic [7:1] addr,
  input  nibbleT     dIn,
  output logic       acTack,
  acRegIf.fsm        bus
);

  typedef enum logic [1:0] {
    stIdle  = 2'd0,
    stRead  = 2'd1,
    stWrite = 2'd2,
    stAck   = 2'd3
  } stateT;

  stateT      state;
  logic       tsHit;     // Set after E0
  logic       startQ;    // Set after E1
  logic       rnWQ;
  logic [7:0] ofsQ;
  nibbleT     nibQ;
  logic       goCycle;

  //////////////////////////////////////////////////////////////////////
  // Cycle start
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      tsHit  <= 1'b0;
      startQ <= 1'b0;
    end else begin
      tsHit  <= autoconfigSpace && !tsN && !bus.chainDone;  // Silent once chain is done
      startQ <= tsHit;
    end
  end

  // Address, write data and direction are held for the rest of the cycle
  always_ff @(posedge CLK40) begin
    if (tsHit) begin
      ofsQ <= {addr, 1'b0};
      nibQ <= dIn;
      rnWQ <= rnW;
    end
  end

  assign goCycle = (state == stIdle) && startQ && !cpuConfN;

  //////////////////////////////////////////////////////////////////////
  // Cycle sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      state        <= stIdle;
      acTack       <= 1'b0;
      bus.writeStb <= 1'b0;
    end else begin
      acTack       <= 1'b0;
      bus.writeStb <= 1'b0;
      case (state)
        stIdle: begin
          if (goCycle && rnWQ) begin
            state <= stRead;
          end else if (goCycle) begin
            state        <= stWrite;
            bus.writeStb <= 1'b1;  // Data modules act at E3
          end
        end
        stRead: begin
          acTack <= 1'b1;          // E3
          state  <= stIdle;
        end
        stWrite: state <= stAck;
        stAck: begin
          acTack <= 1'b1;          // E4
          state  <= stIdle;
        end
        default: state <= stIdle;
      endcase
    end
  end

  assign bus.readStb  = goCycle && rnWQ;  // ROM loads dOut at E2
  assign bus.regOfs   = ofsQ;
  assign bus.wrNibble = nibQ;

  ackOnePulse: assert property (@(posedge CLK40) disable iff (!RESETn)
    acTack |=> !acTack);

  strobesExclusive: assert property (@(posedge CLK40) disable iff (!RESETn)
    !(bus.readStb && bus.writeStb));

endmodule

//--- rtl/acChainCounter.sv
`timescale 1ns/1ps

module acChainCounter
  import autoconfPkg::*;
(
  input  logic  CLK40,
  input  logic  RESETn,
  input  logic  boardDone,
  output logic  configured,
  output logic  configEnN,
  acRegIf.chain bus
);

  boardIdxT idxQ;
  logic     doneQ;

  //////////////////////////////////////////////////////////////////////
  // Chain position
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      idxQ       <= BOARD_BRIDGE;
      doneQ      <= 1'b0;
      configured <= 1'b0;
      configEnN  <= 1'b1;  // Next card waits
    end else if (boardDone && !doneQ) begin
      if (idxQ == BOARD_PRO) begin
        // Last board finished, hand over to the next card
        doneQ      <= 1'b1;
        configured <= 1'b1;
        configEnN  <= 1'b0;
      end else begin
        idxQ <= idxQ + 2'd1;
      end
    end
  end

  assign bus.boardIdx  = idxQ;
  assign bus.chainDone = doneQ;

  idxInRange: assert property (@(posedge CLK40) disable iff (!RESETn)
    bus.boardIdx <= BOARD_PRO);

endmodule

//--- rtl/acDescriptorRom.sv
`timescale 1ns/1ps

module acDescriptorRom
  import autoconfPkg::*;
(
  input  logic CLK40,
  input  logic RESETn,
  input  logic autoBoot,
  output nibbleT dOut,
  acRegIf.data bus
);

  nibbleT descNib;

  //////////////////////////////////////////////////////////////////////
  // Descriptor table
  //////////////////////////////////////////////////////////////////////

  function automatic nibbleT descLookup(boardIdxT brd, logic [7:0] ofs, logic boot);
    logic [7:0]  pid;
    logic [15:0] mfr;
    nibbleT      flags;
    nibbleT      raw;
    int unsigned sel;
    pid   = BRIDGE_PID;
    mfr   = MFR_ID;
    flags = 4'hC;
    if (brd == BOARD_LIDE) begin
      pid   = LIDE_PID;
      flags = 4'h4;
    end else if (brd == BOARD_PRO) begin
      pid   = PRO_PID;
      mfr   = PRO_MFR_ID;
      flags = 4'h7;
    end
    raw = 4'h0;                                    // Reads back as 0xF
    case (ofs)
      // The first two nibbles are returned as is
      OFS_TYPE: begin
        if (brd == BOARD_LIDE) begin
          return {3'b110, boot};                   // Autoboot bit for the IDE
        end else if (brd == BOARD_PRO) begin
          return 4'h8;
        end
        return 4'hC;
      end
      OFS_SIZE: begin
        if (brd == BOARD_LIDE) begin
          return 4'h2;
        end else if (brd == BOARD_PRO) begin
          return 4'h5;
        end
        return 4'h1;
      end
      OFS_PROD_HI: raw = pid[7:4];
      OFS_PROD_LO: raw = pid[3:0];
      OFS_FLAGS:   raw = flags;
      default: begin
        if (ofs >= OFS_MFR_0 && ofs <= OFS_MFR_3) begin
          sel = 32'(ofs - OFS_MFR_0) >> 1;         // 0 is the MS nibble
          raw = mfr[(3 - sel) * 4 +: 4];
        end else if (ofs >= OFS_SER_0 && ofs <= OFS_SER_7) begin
          sel = 32'(ofs - OFS_SER_0) >> 1;
          raw = SERIAL_NUM[(7 - sel) * 4 +: 4];
        end
      end
    endcase
    return ~raw;                                   // Rest of the table is inverted
  endfunction

  assign descNib = descLookup(bus.boardIdx, bus.regOfs, autoBoot);

  //////////////////////////////////////////////////////////////////////
  // Read data register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      dOut <= 4'h0;
    end else if (bus.chainDone) begin
      dOut <= 4'hF;                                // Chain done, bus reads idle
    end else if (bus.readStb) begin
      dOut <= descNib;
    end
  end

endmodule

//--- rtl/acBaseRegs.sv
`timescale 1ns/1ps

module acBaseRegs
  import autoconfPkg::*;
(
  input  logic       CLK40,
  input  logic       RESETn,
  output logic       boardDone,
  output logic [7:0] bridgeBase,
  output logic [7:1] lideBase,
  output logic [2:0] proBase,
  acRegIf.data       bus
);

  logic loWrite;
  logic hiWrite;

  assign loWrite = bus.writeStb && (bus.regOfs == OFS_BASE_LO);
  assign hiWrite = bus.writeStb && (bus.regOfs == OFS_BASE_HI);

  // Taking the high nibble finishes the current board
  assign boardDone = hiWrite;

  //////////////////////////////////////////////////////////////////////
  // Base address registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      bridgeBase <= 8'h00;
      lideBase   <= 7'h00;
      proBase    <= 3'b000;
    end else if (loWrite) begin
      case (bus.boardIdx)
        BOARD_BRIDGE: bridgeBase[3:0] <= bus.wrNibble;
        BOARD_LIDE:   lideBase[3:1]   <= bus.wrNibble[3:1];  // 128K granularity
        default: ;                                           // ROM board has no low half
      endcase
    end else if (hiWrite) begin
      case (bus.boardIdx)
        BOARD_BRIDGE: bridgeBase[7:4] <= bus.wrNibble;
        BOARD_LIDE:   lideBase[7:4]   <= bus.wrNibble;
        default:      proBase         <= bus.wrNibble[3:1];
      endcase
    end
  end

  noWriteWhenDone: assert property (@(posedge CLK40) disable iff (!RESETn)
    bus.writeStb |-> !bus.chainDone);

endmodule

//--- rtl/acTop.sv
`timescale 1ns/1ps

module acTop (
  input  logic       CLK40,
  input  logic       RESETn,
  input  logic       autoconfigSpace,
  input  logic       rnW,
  input  logic       tsN,
  input  logic       autoBoot,
  input  logic       cpuConfN,
  input  logic [3:0] dIn,         // D31-28
  input  logic [7:1] addr,
  output logic       configEnN,
  output logic       configured,
  output logic       acTack,
  output logic [7:0] bridgeBase,
  output logic [7:1] lideBase,
  output logic [2:0] proBase,
  output logic [3:0] dOut         // D31-28
);

  logic boardDone;

  acRegIf acBus ();

  //////////////////////////////////////////////////////////////////////
  // Cycle control
  //////////////////////////////////////////////////////////////////////

  acCycleFsm uCycleFsm (
    .CLK40           (CLK40),
    .RESETn          (RESETn),
    .autoconfigSpace (autoconfigSpace),
    .tsN             (tsN),
    .rnW             (rnW),
    .cpuConfN        (cpuConfN),
    .addr            (addr),
    .dIn             (dIn),
    .acTack          (acTack),
    .bus             (acBus.fsm)
  );

  acChainCounter uChainCounter (
    .CLK40      (CLK40),
    .RESETn     (RESETn),
    .boardDone  (boardDone),
    .configured (configured),
    .configEnN  (configEnN),
    .bus        (acBus.chain)
  );

  //////////////////////////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////////////////////////

  acDescriptorRom uDescriptorRom (
    .CLK40    (CLK40),
    .RESETn   (RESETn),
    .autoBoot (autoBoot),
    .dOut     (dOut),
    .bus      (acBus.data)
  );

  acBaseRegs uBaseRegs (
    .CLK40      (CLK40),
    .RESETn     (RESETn),
    .boardDone  (boardDone),
    .bridgeBase (bridgeBase),
    .lideBase   (lideBase),
    .proBase    (proBase),
    .bus        (acBus.data)
  );

endmodule

//--- bench/acTb.sv
`timescale 1ns/1ps

module acTb
  import autoconfPkg::*;
();

  localparam int ACK_TIMEOUT = 20;  // Cycles

  logic        CLK40;
  logic        RESETn;
  logic        autoconfigSpace;
  logic        rnW;
  logic        tsN;
  logic        autoBoot;
  logic        cpuConfN;
  nibbleT      dIn;
  logic [7:1]  addr;
  logic        configEnN;
  logic        configured;
  logic        acTack;
  logic [7:0]  bridgeBase;
  logic [7:1]  lideBase;
  logic [2:0]  proBase;
  nibbleT      dOut;

  string       testName;
  nibbleT      expNib;
  logic [7:0]  expBridge;
  logic [7:1]  expLide;
  logic [2:0]  expPro;
  logic        rdCheck;
  logic        wrCheck;
  logic        holdCheck;   // dOut and bases must not move
  int          dataErrs;
  int          ackErrs;
  int          stateErrs;
  boardIdxT    board;       // Board the host is talking to
  logic [17:0] allBases;
  logic        startRd;
  logic        startWr;

  acTop DUT (.*);

  initial CLK40 = 1'b0;
  always #20 CLK40 = ~CLK40;

  assign allBases = {bridgeBase, lideBase, proBase};
  assign startRd  = autoconfigSpace && !tsN && !configured && !cpuConfN && rnW;   // Edge E0
  assign startWr  = autoconfigSpace && !tsN && !configured && !cpuConfN && !rnW;

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  readData: assert property (@(posedge CLK40) disable iff (!RESETn)
    (acTack && rdCheck) |-> (dOut == expNib))
    else begin
      dataErrs = dataErrs + 1;
      $display("Fail %s: expected %h actual %h", testName, expNib, $sampled(dOut));
    end

  baseValues: assert property (@(posedge CLK40) disable iff (!RESETn)
    (acTack && wrCheck) |-> (allBases == {expBridge, expLide, expPro}))
    else begin
      dataErrs = dataErrs + 1;
      $display("Fail %s: expected bases %h actual %h", testName,
               {expBridge, expLide, expPro}, $sampled(allBases));
    end

  readLatency: assert property (@(posedge CLK40) disable iff (!RESETn)
    $past(startRd, 4) |-> acTack)
    else begin
      ackErrs = ackErrs + 1;
      $display("%s: read acknowledge not 3 edges after the cycle start", testName);
    end

  writeLatency: assert property (@(posedge CLK40) disable iff (!RESETn)
    $past(startWr, 5) |-> acTack)
    else begin
      ackErrs = ackErrs + 1;
      $display("%s: write acknowledge not 4 edges after the cycle start", testName);
    end

  ackSource: assert property (@(posedge CLK40) disable iff (!RESETn)
    acTack |-> ($past(startRd, 4) || $past(startWr, 5)))
    else begin
      ackErrs = ackErrs + 1;
      $display("%s: acknowledge without a matching host cycle", testName);
    end

  ackWidth: assert property (@(posedge CLK40) disable iff (!RESETn)
    acTack |=> !acTack)
    else begin
      ackErrs = ackErrs + 1;
      $display("%s: acknowledge longer than one cycle", testName);
    end

  silentData: assert property (@(posedge CLK40) disable iff (!RESETn)
    $past(configured) |-> (dOut == 4'hF))
    else begin
      dataErrs = dataErrs + 1;
      $display("Fail %s: expected f actual %h", testName, $sampled(dOut));
    end

  silentBases: assert property (@(posedge CLK40) disable iff (!RESETn)
    $past(configured) |-> $stable(allBases))
    else begin
      stateErrs = stateErrs + 1;
      $display("%s: a base changed after configuration", testName);
    end

  heldState: assert property (@(posedge CLK40) disable iff (!RESETn)
    holdCheck |-> ($stable(dOut) && $stable(allBases)))
    else begin
      stateErrs = stateErrs + 1;
      $display("%s: dOut or a base changed on an ignored cycle", testName);
    end

  enableOut: assert property (@(posedge CLK40) disable iff (!RESETn)
    configEnN == !configured)
    else begin
      stateErrs = stateErrs + 1;
      $display("%s: configEnN does not follow configured", testName);
    end

  //////////////////////////////////////////////////////////////////////
  // Expected descriptor and host cycles
  //////////////////////////////////////////////////////////////////////

  function automatic nibbleT descriptorNibble(boardIdxT brd, logic [7:0] ofs, logic boot);
    logic [7:0]  pid;
    logic [47:0] idWord;  // Manufacturer, then serial number
    nibbleT      flagNib;
    int          k;
    pid     = (brd == BOARD_BRIDGE) ? BRIDGE_PID : (brd == BOARD_LIDE) ? LIDE_PID : PRO_PID;
    flagNib = (brd == BOARD_BRIDGE) ? 4'hC : (brd == BOARD_LIDE) ? 4'h4 : 4'h7;
    idWord  = {(brd == BOARD_PRO) ? PRO_MFR_ID : MFR_ID, SERIAL_NUM};
    k       = (int'(ofs) - 16) / 2;  // Nibble index from 0x10
    case (ofs)
      8'h00: return (brd == BOARD_BRIDGE) ? 4'hC :
                    (brd == BOARD_LIDE) ? {3'b110, boot} : 4'h8;
      8'h02: return (brd == BOARD_BRIDGE) ? 4'h1 : (brd == BOARD_LIDE) ? 4'h2 : 4'h5;
      8'h04: return ~pid[7:4];
      8'h06: return ~pid[3:0];
      8'h08: return ~flagNib;
      default: return (ofs >= 8'h10 && k < 12) ? ~idWord[47 - 4 * k -: 4] : 4'hF;
    endcase
  endfunction

  task automatic startCycle(input logic [7:0] ofs, input logic isRead, input nibbleT nib);
    @(posedge CLK40);
    #2;
    autoconfigSpace = 1'b1;
    rnW             = isRead;
    addr            = ofs[7:1];
    dIn             = nib;
    tsN             = 1'b0;
    @(posedge CLK40);  // E0
    #2;
    tsN = 1'b1;
  endtask

  task automatic awaitAck(input logic expectAck);
    logic got;
    got = 1'b0;
    for (int n = 0; n < ACK_TIMEOUT && !got; n++) begin
      @(negedge CLK40);
      got = acTack;
    end
    if (expectAck && !got) begin
      ackErrs = ackErrs + 1;
      $display("%s: no acknowledge within %0d cycles", testName, ACK_TIMEOUT);
    end
    @(posedge CLK40);  // Checks see the acknowledge here
    #2;
    rdCheck         = 1'b0;
    wrCheck         = 1'b0;
    autoconfigSpace = 1'b0;
  endtask

  task automatic hostRead(input logic [7:0] ofs, input logic expectAck);
    expNib  = descriptorNibble(board, ofs, autoBoot);
    rdCheck = expectAck;
    startCycle(ofs, 1'b1, 4'h0);
    awaitAck(expectAck);
  endtask

  task automatic hostWrite(input logic [7:0] ofs, input nibbleT nib, input logic expectAck);
    wrCheck = expectAck;
    startCycle(ofs, 1'b0, nib);
    awaitAck(expectAck);
  endtask

  task automatic readRange(input logic [7:0] first, input logic [7:0] last);
    logic [7:0] ofs;
    ofs = first;
    while (ofs <= last) begin
      hostRead(ofs, 1'b1);
      ofs = ofs + 8'h02;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    RESETn          = 1'b0;
    autoconfigSpace = 1'b0;
    rnW             = 1'b1;
    tsN             = 1'b1;
    autoBoot        = 1'b1;
    cpuConfN        = 1'b0;
    dIn             = 4'h0;
    addr            = 7'h00;
    testName        = "reset";
    expNib          = 4'h0;
    expBridge       = 8'h00;
    expLide         = 7'h00;
    expPro          = 3'b000;
    rdCheck         = 1'b0;
    wrCheck         = 1'b0;
    holdCheck       = 1'b0;
    dataErrs        = 0;
    ackErrs         = 0;
    stateErrs       = 0;
    board           = BOARD_BRIDGE;
    repeat (10) @(posedge CLK40);
    #2;
    RESETn = 1'b1;

    testName = "bridge descriptor";
    readRange(8'h00, 8'h26);
    hostRead(8'h30, 1'b1);  // Undefined offset

    testName  = "cpuConfN gating";
    cpuConfN  = 1'b1;
    holdCheck = 1'b1;
    hostRead(8'h00, 1'b0);  // Would load 0xC over 0xF
    hostWrite(OFS_BASE_HI, 4'h6, 1'b0);
    holdCheck = 1'b0;
    cpuConfN  = 1'b0;

    testName       = "bridge base";
    expBridge[3:0] = 4'h5;
    hostWrite(OFS_BASE_LO, 4'h5, 1'b1);
    expBridge[7:4] = 4'hE;
    hostWrite(OFS_BASE_HI, 4'hE, 1'b1);
    board = BOARD_LIDE;

    testName = "IDE descriptor";
    readRange(8'h00, 8'h26);

    testName = "IDE autoboot";
    hostRead(8'h00, 1'b1);
    autoBoot = 1'b0;
    hostRead(8'h00, 1'b1);
    autoBoot = 1'b1;

    testName     = "IDE base";
    expLide[3:1] = 3'b011;
    hostWrite(OFS_BASE_LO, 4'h7, 1'b1);
    expLide[7:4] = 4'h9;
    hostWrite(OFS_BASE_HI, 4'h9, 1'b1);
    board = BOARD_PRO;

    testName = "ROM board descriptor";
    readRange(8'h00, 8'h16);

    testName = "ROM board base";
    hostWrite(OFS_BASE_LO, 4'hB, 1'b1);  // No low half on this board
    expPro = 3'b110;
    hostWrite(OFS_BASE_HI, 4'hD, 1'b1);
    chainReported: assert (configured && !configEnN)
      else begin
        stateErrs = stateErrs + 1;
        $display("%s: chain not configured after the last board", testName);
      end

    testName = "silence";
    hostRead(8'h00, 1'b0);
    hostWrite(OFS_BASE_HI, 4'h1, 1'b0);
    hostWrite(OFS_BASE_LO, 4'h2, 1'b0);

    $display("Errors: data %0d, acknowledge %0d, state %0d", dataErrs, ackErrs, stateErrs);
    if (dataErrs + ackErrs + stateErrs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
rtl/autoconfPkg.sv
rtl/acRegIf.sv
rtl/acCycleFsm.sv
rtl/acChainCounter.sv
rtl/acDescriptorRom.sv
rtl/acBaseRegs.sv
rtl/acTop.sv
bench/acTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module acTb -Mdir obj_dir -o acSim \
  -f filelist.f || exit 1
simOut=$(./obj_dir/acSim)
echo "$simOut"
echo "$simOut" | grep -qx "TB PASSED" && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}
